/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lpif_link_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+src
src/llink_pkg.sv
src/lpif_auto_sync.sv
src/lpif_flit_stage.sv
src/lpif_lane_stage.sv
src/lpif_link_top.sv
tests/lpif_link_assertions.sv
tests/lpif_link_tb.sv

/* src/llink_defs.svh */
`ifndef LLINK_DEFS_SVH
`define LLINK_DEFS_SVH

// User field widths of one flit
`define LL_STATE_W         4
`define LL_PROTID_W        2
`define LL_DATA_W          256
`define LL_BSTART_W        5
`define LL_BVALID_W        32

// Whole flit, sum of the user fields plus the valid bit
`define LL_FLIT_W          300

// PHY side of the x16 link
`define LL_LANES           4
`define LL_PHY_W           80

// Flit bits carried on each lane word
`define LL_LANE_PAYLOAD_W  75

// Per-lane sync bits above the payload
// Bits 77 to 79 are spare and driven low
`define LL_STB_BIT         75
`define LL_MRK_BIT         76

// Online delay configuration values
`define LL_DELAY_W         8

`endif

/* src/llink_pkg.sv */
`include "llink_defs.svh"

package llink_pkg;

  // One 300-bit flit, seen as user fields or as lane slices
  typedef union packed {
    // Field view, most significant first
    struct packed {
      logic                      valid;
      logic [`LL_BVALID_W-1:0]   bvalid;
      logic [`LL_BSTART_W-1:0]   bstart;
      logic [`LL_DATA_W-1:0]     data;
      logic [`LL_PROTID_W-1:0]   protid;
      logic [`LL_STATE_W-1:0]    state;
    } fields;

    // Slice view, lane 0 in the low bits
    logic [`LL_LANES-1:0][`LL_FLIT_W/`LL_LANES-1:0] lane;
  } llink_flit_u;

endpackage

/* src/lpif_auto_sync.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_auto_sync (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  input  logic                   tx_online,
  input  logic                   rx_online,

  input  logic                   m_gen2_mode,
  input  logic [`LL_DELAY_W-1:0] delay_x_value,
  input  logic [`LL_DELAY_W-1:0] delay_xz_value,
  input  logic [`LL_DELAY_W-1:0] delay_yz_value,

  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   tx_stb_bit,
  output logic                   tx_mrk_bit
);

  logic [`LL_DELAY_W-1:0] tx_xz_cnt;
  logic [`LL_DELAY_W-1:0] rx_x_cnt;
  logic [`LL_DELAY_W-1:0] rx_yz_cnt;
  logic                   mrk_phase;

  ////////////////////////////////////////
  // TX online delay

  // Counts consecutive cycles of tx_online, sticks at all ones
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_xz_cnt       <= '0;
      tx_online_delay <= 1'b0;
    end else if (!tx_online) begin
      tx_xz_cnt       <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      if (tx_xz_cnt != '1) begin
        tx_xz_cnt <= tx_xz_cnt + 1'b1;
      end
      tx_online_delay <= (tx_xz_cnt >= delay_xz_value);
    end
  end

  ////////////////////////////////////////
  // RX online delay

  // Both counters restart whenever rx_online drops
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_x_cnt        <= '0;
      rx_yz_cnt       <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      rx_x_cnt        <= '0;
      rx_yz_cnt       <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (rx_x_cnt != '1) begin
        rx_x_cnt <= rx_x_cnt + 1'b1;
      end
      // Far side must have been sending long enough too
      if (tx_online_delay && (rx_yz_cnt != '1)) begin
        rx_yz_cnt <= rx_yz_cnt + 1'b1;
      end
      rx_online_delay <= (rx_x_cnt >= delay_x_value) &&
                         (rx_yz_cnt >= delay_yz_value);
    end
  end

  ////////////////////////////////////////
  // Strobe and marker

  // Word phase for gen2, low on the first word after online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      mrk_phase <= 1'b0;
    end else if (!tx_online_delay) begin
      mrk_phase <= 1'b0;
    end else begin
      mrk_phase <= ~mrk_phase;
    end
  end

  // Persistent strobe on every word
  assign tx_stb_bit = tx_online_delay;

  // Gen1 marks every word, gen2 every second one
  assign tx_mrk_bit = m_gen2_mode ? mrk_phase : tx_online_delay;

endmodule

/* src/lpif_flit_stage.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_flit_stage import llink_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Downstream user channel
  input  logic [`LL_STATE_W-1:0]  dstrm_state,
  input  logic [`LL_PROTID_W-1:0] dstrm_protid,
  input  logic [`LL_DATA_W-1:0]   dstrm_data,
  input  logic [`LL_BSTART_W-1:0] dstrm_bstart,
  input  logic [`LL_BVALID_W-1:0] dstrm_bvalid,
  input  logic                    dstrm_valid,

  output llink_flit_u             tx_flit,

  input  llink_flit_u             rx_flit,

  // Upstream user channel
  output logic [`LL_STATE_W-1:0]  ustrm_state,
  output logic [`LL_PROTID_W-1:0] ustrm_protid,
  output logic [`LL_DATA_W-1:0]   ustrm_data,
  output logic [`LL_BSTART_W-1:0] ustrm_bstart,
  output logic [`LL_BVALID_W-1:0] ustrm_bvalid,
  output logic                    ustrm_valid
);

  ////////////////////////////////////////
  // TX packing

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flit <= '0;
    end else begin
      tx_flit.fields.state  <= dstrm_state;
      tx_flit.fields.protid <= dstrm_protid;
      tx_flit.fields.data   <= dstrm_data;
      tx_flit.fields.bstart <= dstrm_bstart;
      tx_flit.fields.bvalid <= dstrm_bvalid;
      tx_flit.fields.valid  <= dstrm_valid;
    end
  end

  ////////////////////////////////////////
  // RX unpacking

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm_state  <= '0;
      ustrm_protid <= '0;
      ustrm_data   <= '0;
      ustrm_bstart <= '0;
      ustrm_bvalid <= '0;
      ustrm_valid  <= 1'b0;
    end else begin
      ustrm_state  <= rx_flit.fields.state;
      ustrm_protid <= rx_flit.fields.protid;
      ustrm_data   <= rx_flit.fields.data;
      ustrm_bstart <= rx_flit.fields.bstart;
      ustrm_bvalid <= rx_flit.fields.bvalid;
      // Already cleared upstream while RX is offline
      ustrm_valid  <= rx_flit.fields.valid;
    end
  end

endmodule

/* src/lpif_lane_stage.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_lane_stage import llink_pkg::*; (
  input  logic                 clk_wr,
  input  logic                 rst_n,

  input  llink_flit_u          tx_flit,
  input  logic                 tx_online_delay,
  input  logic                 tx_stb_bit,
  input  logic                 tx_mrk_bit,
  input  logic                 rx_online_delay,

  // PHY lanes
  output logic [`LL_PHY_W-1:0] tx_phy0,
  output logic [`LL_PHY_W-1:0] tx_phy1,
  output logic [`LL_PHY_W-1:0] tx_phy2,
  output logic [`LL_PHY_W-1:0] tx_phy3,
  input  logic [`LL_PHY_W-1:0] rx_phy0,
  input  logic [`LL_PHY_W-1:0] rx_phy1,
  input  logic [`LL_PHY_W-1:0] rx_phy2,
  input  logic [`LL_PHY_W-1:0] rx_phy3,

  output llink_flit_u          rx_flit
);

  logic [`LL_LANES-1:0][`LL_PHY_W-1:0] tx_word_next;
  logic [`LL_LANES-1:0][`LL_PHY_W-1:0] tx_word;
  logic [`LL_LANES-1:0][`LL_PHY_W-1:0] rx_word;
  llink_flit_u                         rx_gather;

  ////////////////////////////////////////
  // TX lane split

  // Spare bits above the marker stay zero
  always_comb begin
    tx_word_next = '0;
    for (int i = 0; i < `LL_LANES; i++) begin
      tx_word_next[i][`LL_LANE_PAYLOAD_W-1:0] = tx_flit.lane[i];
      tx_word_next[i][`LL_STB_BIT]            = tx_stb_bit;
      tx_word_next[i][`LL_MRK_BIT]            = tx_mrk_bit;
    end
  end

  // Nothing leaves on the lanes until TX is online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_word <= '0;
    end else if (!tx_online_delay) begin
      tx_word <= '0;
    end else begin
      tx_word <= tx_word_next;
    end
  end

  assign tx_phy0 = tx_word[0];
  assign tx_phy1 = tx_word[1];
  assign tx_phy2 = tx_word[2];
  assign tx_phy3 = tx_word[3];

  ////////////////////////////////////////
  // RX lane gather

  assign rx_word = {rx_phy3, rx_phy2, rx_phy1, rx_phy0};

  // Received strobe and marker are dropped here
  always_comb begin
    rx_gather = '0;
    for (int i = 0; i < `LL_LANES; i++) begin
      rx_gather.lane[i] = rx_word[i][`LL_LANE_PAYLOAD_W-1:0];
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_flit <= '0;
    end else if (!rx_online_delay) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= rx_gather;
    end
  end

endmodule

/* src/lpif_link_top.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_link_top import llink_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Control
  input  logic                    tx_online,
  input  logic                    rx_online,

  // Configuration
  input  logic                    m_gen2_mode,
  input  logic [`LL_DELAY_W-1:0]  delay_x_value,
  input  logic [`LL_DELAY_W-1:0]  delay_xz_value,
  input  logic [`LL_DELAY_W-1:0]  delay_yz_value,

  // Downstream channel
  input  logic [`LL_STATE_W-1:0]  dstrm_state,
  input  logic [`LL_PROTID_W-1:0] dstrm_protid,
  input  logic [`LL_DATA_W-1:0]   dstrm_data,
  input  logic [`LL_BSTART_W-1:0] dstrm_bstart,
  input  logic [`LL_BVALID_W-1:0] dstrm_bvalid,
  input  logic                    dstrm_valid,

  // Upstream channel
  output logic [`LL_STATE_W-1:0]  ustrm_state,
  output logic [`LL_PROTID_W-1:0] ustrm_protid,
  output logic [`LL_DATA_W-1:0]   ustrm_data,
  output logic [`LL_BSTART_W-1:0] ustrm_bstart,
  output logic [`LL_BVALID_W-1:0] ustrm_bvalid,
  output logic                    ustrm_valid,

  // PHY interconnect
  output logic [`LL_PHY_W-1:0]    tx_phy0,
  output logic [`LL_PHY_W-1:0]    tx_phy1,
  output logic [`LL_PHY_W-1:0]    tx_phy2,
  output logic [`LL_PHY_W-1:0]    tx_phy3,
  input  logic [`LL_PHY_W-1:0]    rx_phy0,
  input  logic [`LL_PHY_W-1:0]    rx_phy1,
  input  logic [`LL_PHY_W-1:0]    rx_phy2,
  input  logic [`LL_PHY_W-1:0]    rx_phy3
);

  ////////////////////////////////////////
  // Interconnect

  llink_flit_u tx_flit;
  llink_flit_u rx_flit;
  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        tx_stb_bit;
  logic        tx_mrk_bit;

  ////////////////////////////////////////
  // Auto sync

  lpif_auto_sync sync0 (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .m_gen2_mode     (m_gen2_mode),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit)
  );

  ////////////////////////////////////////
  // User side, fields to flit and back

  lpif_flit_stage flit0 (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .dstrm_state  (dstrm_state),
    .dstrm_protid (dstrm_protid),
    .dstrm_data   (dstrm_data),
    .dstrm_bstart (dstrm_bstart),
    .dstrm_bvalid (dstrm_bvalid),
    .dstrm_valid  (dstrm_valid),
    .tx_flit      (tx_flit),
    .rx_flit      (rx_flit),
    .ustrm_state  (ustrm_state),
    .ustrm_protid (ustrm_protid),
    .ustrm_data   (ustrm_data),
    .ustrm_bstart (ustrm_bstart),
    .ustrm_bvalid (ustrm_bvalid),
    .ustrm_valid  (ustrm_valid)
  );

  ////////////////////////////////////////
  // PHY side, flit to lanes and back

  lpif_lane_stage lane0 (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit),
    .rx_online_delay (rx_online_delay),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .tx_phy3         (tx_phy3),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_phy3         (rx_phy3),
    .rx_flit         (rx_flit)
  );

endmodule

/* tests/lpif_link_assertions.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_link_assertions (
  input logic                 clk_wr,
  input logic                 rst_n,
  input logic                 m_gen2_mode,
  input logic                 rx_online_delay,
  input logic                 tx_stb_bit,
  input logic                 ustrm_valid,
  input logic [`LL_PHY_W-1:0] tx_phy0,
  input logic [`LL_PHY_W-1:0] tx_phy1,
  input logic [`LL_PHY_W-1:0] tx_phy2,
  input logic [`LL_PHY_W-1:0] tx_phy3
);

  int         fail_count = 0;
  logic [3:0] stb_lanes;
  logic [3:0] mrk_lanes;

  assign stb_lanes = {tx_phy3[`LL_STB_BIT], tx_phy2[`LL_STB_BIT],
                      tx_phy1[`LL_STB_BIT], tx_phy0[`LL_STB_BIT]};
  assign mrk_lanes = {tx_phy3[`LL_MRK_BIT], tx_phy2[`LL_MRK_BIT],
                      tx_phy1[`LL_MRK_BIT], tx_phy0[`LL_MRK_BIT]};

  ////////////////////////////////////////
  // Online gating

  // Lane register clears on the edge where the strobe was low
  stb_gated: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !$past(tx_stb_bit) |-> (stb_lanes == 4'h0))
  else begin
    fail_count++;
    $error("strobe on a lane one edge after tx_stb_bit was low");
  end

  // Two register stages between rx_online_delay and ustrm_valid
  rx_gated: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !$past(rx_online_delay, 2) |-> !ustrm_valid)
  else begin
    fail_count++;
    $error("ustrm_valid high two edges after rx_online_delay was low");
  end

  ////////////////////////////////////////
  // Gen2 marker

  // Lane markers flip on every word while the strobe stays up
  mrk_toggle: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (m_gen2_mode && (stb_lanes == 4'hf) && ($past(stb_lanes) == 4'hf)) |->
      (mrk_lanes == ~$past(mrk_lanes)))
  else begin
    fail_count++;
    $error("gen2 marker on the lanes did not alternate while the strobe stayed high");
  end

endmodule

bind lpif_link_top lpif_link_assertions assert0 (.*);

/* tests/lpif_link_tb.sv */
`timescale 1ns/100ps
`include "llink_defs.svh"

module lpif_link_tb;

  localparam int num_rows       = 6;
  localparam int timeout_cycles = 100;

  // Per test {gen2, delay_x, delay_xz, delay_yz}
  localparam logic [24:0] cfg_table [2] = '{{1'b0, 8'd6, 8'd3, 8'd2},
                                            {1'b1, 8'd10, 8'd5, 8'd4}};

  // Per row {valid, bstart, protid, state}
  localparam logic [11:0] row_fixed [num_rows] = '{
    {1'b1, 5'd0, 2'd0, 4'h1}, {1'b1, 5'd4, 2'd1, 4'h3}, {1'b0, 5'd8, 2'd2, 4'h7},
    {1'b1, 5'd16, 2'd3, 4'hf}, {1'b1, 5'd31, 2'd1, 4'h0}, {1'b1, 5'd12, 2'd2, 4'ha}};

  logic [`LL_DATA_W-1:0]   row_data   [num_rows];
  logic [`LL_BVALID_W-1:0] row_bvalid [num_rows];

  logic                    clk_wr;
  logic                    rst_n;
  logic                    tx_online;
  logic                    rx_online;
  logic                    m_gen2_mode;
  logic [`LL_DELAY_W-1:0]  delay_x_value;
  logic [`LL_DELAY_W-1:0]  delay_xz_value;
  logic [`LL_DELAY_W-1:0]  delay_yz_value;
  logic [`LL_STATE_W-1:0]  dstrm_state;
  logic [`LL_PROTID_W-1:0] dstrm_protid;
  logic [`LL_DATA_W-1:0]   dstrm_data;
  logic [`LL_BSTART_W-1:0] dstrm_bstart;
  logic [`LL_BVALID_W-1:0] dstrm_bvalid;
  logic                    dstrm_valid;
  logic [`LL_STATE_W-1:0]  ustrm_state;
  logic [`LL_PROTID_W-1:0] ustrm_protid;
  logic [`LL_DATA_W-1:0]   ustrm_data;
  logic [`LL_BSTART_W-1:0] ustrm_bstart;
  logic [`LL_BVALID_W-1:0] ustrm_bvalid;
  logic                    ustrm_valid;
  logic [`LL_PHY_W-1:0]    tx_phy0;
  logic [`LL_PHY_W-1:0]    tx_phy1;
  logic [`LL_PHY_W-1:0]    tx_phy2;
  logic [`LL_PHY_W-1:0]    tx_phy3;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     errors_at_start;
  int     n;
  int     exp_q [$];
  logic   lanes_live;
  logic   exp_mrk;
  logic   timed_out;
  string  mode_name;

  // External loopback on all four lanes
  lpif_link_top dut0 (.*, .rx_phy0(tx_phy0), .rx_phy1(tx_phy1),
                      .rx_phy2(tx_phy2), .rx_phy3(tx_phy3));

  always #10 clk_wr = ~clk_wr;

  ////////////////////////////////////////
  // Helpers

  task automatic compare_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  function automatic logic [3:0] lane_bits(input int b);
    return {tx_phy3[b], tx_phy2[b], tx_phy1[b], tx_phy0[b]};
  endfunction

  function automatic logic lanes_zero();
    return (tx_phy0 | tx_phy1 | tx_phy2 | tx_phy3) == '0;
  endfunction

  task automatic drive_row(input int r);
    {dstrm_valid, dstrm_bstart, dstrm_protid, dstrm_state} <= row_fixed[r];
    dstrm_data   <= row_data[r];
    dstrm_bvalid <= row_bvalid[r];
  endtask

  task automatic match_row(input int r);
    compare_value("ustrm_state", 256'(row_fixed[r][3:0]), 256'(ustrm_state));
    compare_value("ustrm_protid", 256'(row_fixed[r][5:4]), 256'(ustrm_protid));
    compare_value("ustrm_bstart", 256'(row_fixed[r][10:6]), 256'(ustrm_bstart));
    compare_value("ustrm_valid", 256'(row_fixed[r][11]), 256'(ustrm_valid));
    compare_value("ustrm_data", row_data[r], ustrm_data);
    compare_value("ustrm_bvalid", 256'(row_bvalid[r]), 256'(ustrm_bvalid));
  endtask

  // Spare bits, strobe on every lane, marker per mode
  task automatic audit_lanes();
    compare_value("tx_phy spare bits", '0,
                  256'({lane_bits(79), lane_bits(78), lane_bits(77)}));
    compare_value("tx_phy strobe", 256'(4'hf), 256'(lane_bits(`LL_STB_BIT)));
    compare_value("tx_phy marker", 256'({4{exp_mrk}}), 256'(lane_bits(`LL_MRK_BIT)));
    if (m_gen2_mode) begin
      exp_mrk = ~exp_mrk;
    end
  endtask

  task automatic confirm_quiet();
    compare_value("tx_phy lanes", '0, 256'(tx_phy0 | tx_phy1 | tx_phy2 | tx_phy3));
    compare_value("ustrm_valid", '0, 256'(ustrm_valid));
  endtask

  task automatic sample_cycle();
    @(negedge clk_wr);
    if (lanes_live) begin
      audit_lanes();
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  ////////////////////////////////////////
  // Sequence

  task automatic run_sequence();
    repeat (16) begin
      @(negedge clk_wr);
      confirm_quiet();
    end
    @(posedge clk_wr);
    rst_n <= 1'b1;
    close_test("reset");

    for (int c = 0; c < 2; c++) begin
      mode_name = cfg_table[c][24] ? "gen2" : "gen1";
      @(posedge clk_wr);
      {m_gen2_mode, delay_x_value, delay_xz_value, delay_yz_value} <= cfg_table[c];
      repeat (3) begin
        @(negedge clk_wr);
        confirm_quiet();
      end

      // Lanes stay quiet until the strobe shows
      @(posedge clk_wr);
      tx_online <= 1'b1;
      rx_online <= 1'b1;
      for (n = 0; n < timeout_cycles; n++) begin
        @(negedge clk_wr);
        if (lane_bits(`LL_STB_BIT) != 4'h0) break;
        confirm_quiet();
      end
      if (n == timeout_cycles) begin
        report_timeout("strobe never appeared on the lanes");
        return;
      end
      exp_mrk    = ~cfg_table[c][24];
      lanes_live = 1'b1;
      audit_lanes();
      for (n = 0; n < timeout_cycles; n++) begin
        if (dut0.rx_online_delay) break;
        compare_value("ustrm_valid", '0, 256'(ustrm_valid));
        sample_cycle();
      end
      if (n == timeout_cycles) begin
        report_timeout("rx_online_delay never rose");
        return;
      end
      close_test({mode_name, " online"});

      // Each ustrm sample belongs to the row driven 4 edges before
      exp_q.delete();
      for (int i = 0; i < num_rows + 4; i++) begin
        @(posedge clk_wr);
        drive_row(i % num_rows);
        exp_q.push_back(i % num_rows);
        sample_cycle();
        if (exp_q.size() == 5) match_row(exp_q.pop_front());
      end
      close_test({mode_name, " loopback"});

      @(posedge clk_wr);
      rx_online <= 1'b0;
      drive_row(0);
      for (n = 0; n < timeout_cycles; n++) begin
        sample_cycle();
        if (!ustrm_valid) break;
      end
      if (n == timeout_cycles) begin
        report_timeout("ustrm_valid never dropped after rx_online fell");
        return;
      end
      repeat (8) begin
        sample_cycle();
        compare_value("ustrm_valid", '0, 256'(ustrm_valid));
        compare_value("tx_phy3 valid bit", 256'(1'b1),
                      256'(tx_phy3[`LL_LANE_PAYLOAD_W-1]));
      end
      close_test({mode_name, " rx offline"});

      @(posedge clk_wr);
      tx_online  <= 1'b0;
      lanes_live = 1'b0;
      for (n = 0; n < timeout_cycles; n++) begin
        sample_cycle();
        if (lanes_zero()) break;
      end
      if (n == timeout_cycles) begin
        report_timeout("lanes never cleared after tx_online fell");
        return;
      end
      repeat (4) begin
        sample_cycle();
        confirm_quiet();
      end
      close_test({mode_name, " tx offline"});
    end
  endtask

  initial begin
    seed            = 7;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    lanes_live      = 1'b0;
    exp_mrk         = 1'b0;
    timed_out       = 1'b0;
    clk_wr          = 1'b0;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    {m_gen2_mode, delay_x_value, delay_xz_value, delay_yz_value} = '0;
    {dstrm_valid, dstrm_bstart, dstrm_protid, dstrm_state} = '0;
    dstrm_data      = '0;
    dstrm_bvalid    = '0;
    for (int r = 0; r < num_rows; r++) begin
      for (int w = 0; w < `LL_DATA_W / 32; w++) begin
        row_data[r][w*32 +: 32] = $random(seed);
      end
      row_bvalid[r] = $random(seed);
    end

    run_sequence();

    errors += dut0.assert0.fail_count;
    $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, checks, errors, dut0.assert0.fail_count);
    if (!timed_out && errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
